//--- Makefile
VERILATOR ?= verilator
FLIST     ?= flist.f
TOP       ?= mips_core_tb
RTL_TOP   ?= mips_core
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= test passed
FAIL_MSG  ?= test failed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary -j 0 --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/mips_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mips_core_tb;
  import mips_pkg::*;

  localparam int          DMEM_AW  = 8;
  localparam int          PROG_LEN = 64;
  localparam int          TIMEOUT  = 1000;           // cycles
  localparam logic [31:0] END_PC   = 32'd248;        // word 62 jumps to itself
  localparam logic [31:0] NOP_WORD = 32'hfc00_0000;  // unused opcode

  logic        clk;
  logic        rst_n;
  logic [31:0] instr_addr;
  logic        instr_valid;
  logic [31:0] instr_data;
  logic        commit_valid;
  commit_t     commit;
  logic        store_valid;
  store_t      store;

  logic [31:0] rom [PROG_LEN];
  logic [31:0] lfsr;
  commit_t     commit_q [$];
  store_t      store_q [$];
  int          pass_count = 0;
  int          fail_count = 0;
  int          event_count = 0;
  funct_e      alu_functs [6] = '{F_ADD, F_SUB, F_AND, F_OR, F_XOR, F_SLT};
  opcode_e     imm_ops [5] = '{OP_ADDI, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI};

  mips_core #(.DMEM_AW(DMEM_AW)) mips_core_inst (.clk, .rst_n, .instr_addr, .instr_valid,
                                                 .instr_data, .commit_valid, .commit,
                                                 .store_valid, .store);

  assign instr_data = rom[instr_addr[7:2]];  // ROM answers in the same cycle

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // x^32 + x^22 + x^2 + x + 1 stepped once per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      bits = {bits[30:0], lfsr[0]};
    end
    return bits;
  endfunction

  task automatic compare_commit(input string name, input commit_t exp, input commit_t act);
    if (act !== exp) begin
      $display("mismatch %s: expected r%0d=%h, actual r%0d=%h", name,
               exp.reg_addr, exp.data, act.reg_addr, act.data);
      fail_count++;
    end else begin
      pass_count++;
    end
  endtask

  task automatic compare_store(input string name, input store_t exp, input store_t act);
    if (act !== exp) begin
      $display("mismatch %s: expected [%h]=%h, actual [%h]=%h", name,
               exp.addr, exp.data, act.addr, act.data);
      fail_count++;
    end else begin
      pass_count++;
    end
  endtask

  task automatic compare_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("mismatch %s: expected %h, actual %h", name, exp, act);
      fail_count++;
    end else begin
      pass_count++;
    end
  endtask

  task automatic build_program();
    logic [3:0]  cls;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [15:0] imm;
    int          tgt;
    logic        prev_ctl;
    prev_ctl = 1'b0;
    for (int k = 0; k < PROG_LEN - 2; k++) begin
      cls = 4'(take_bits(4));
      rs  = 5'(take_bits(3));
      rt  = 5'(take_bits(3));
      rd  = 5'(take_bits(3));
      imm = 16'(take_bits(16));
      if (cls inside {[4'd12:4'd14]} && (prev_ctl || k == PROG_LEN - 3)) begin
        cls = 4'd4;  // nothing redirects the PC from a delay slot
      end
      case (cls)
        4'd0, 4'd1, 4'd2, 4'd3:
          rom[k] = {OP_RTYPE, rs, rt, rd, 5'd0, alu_functs[int'(take_bits(3)) % 6]};
        4'd4, 4'd5, 4'd6, 4'd7:
          rom[k] = {imm_ops[int'(take_bits(3)) % 5], rs, rt, imm};
        4'd8:         rom[k] = {OP_SPEC, rs, rt, rd, 5'd0, F_MUL};
        4'd9:         rom[k] = {OP_LW, 5'd0, rt, 16'(take_bits(4) * 4)};
        4'd10, 4'd11: rom[k] = {OP_SW, 5'd0, rt, 16'(take_bits(4) * 4)};
        4'd12, 4'd13: begin
          tgt    = k + 2 + int'(take_bits(6)) % (PROG_LEN - 3 - k);  // past the delay slot
          rom[k] = {OP_BEQ, rs, take_bits(1) ? rs : rt, 16'(tgt - k - 1)};
        end
        4'd14: begin
          tgt    = k + 2 + int'(take_bits(6)) % (PROG_LEN - 3 - k);
          rom[k] = {OP_J, 26'(tgt)};
        end
        default: rom[k] = {OP_JAL, 26'(take_bits(26))};  // no-op in this core
      endcase
      prev_ctl = cls inside {[4'd12:4'd14]};
    end
    rom[PROG_LEN-2] = {OP_J, 26'(PROG_LEN - 2)};
    rom[PROG_LEN-1] = NOP_WORD;
  endtask

  // ISA reference with one delay slot after BEQ and J
  task automatic run_model();
    logic [31:0] regs [32];
    logic [31:0] dmem [2**DMEM_AW];
    logic [31:0] pc;
    logic [31:0] npc;
    logic [31:0] nnpc;
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] sext;
    logic [31:0] zext;
    logic [31:0] ea;
    logic [31:0] val;
    logic [4:0]  dst;
    logic        wr;
    int          steps;
    foreach (regs[i]) begin
      regs[i] = '0;
    end
    foreach (dmem[i]) begin
      dmem[i] = '0;
    end
    pc    = '0;
    npc   = 32'd4;
    steps = 0;
    while (pc != END_PC && steps < 4 * PROG_LEN) begin
      ins  = rom[pc[7:2]];
      a    = regs[ins[25:21]];
      b    = regs[ins[20:16]];
      sext = {{16{ins[15]}}, ins[15:0]};
      zext = {16'h0000, ins[15:0]};
      ea   = a + sext;
      nnpc = npc + 32'd4;
      val  = '0;
      wr   = ins[31:26] inside {OP_RTYPE, OP_SPEC, OP_ADDI, OP_SLTI, OP_ANDI, OP_ORI,
                                OP_XORI, OP_LW};
      dst  = (ins[31:26] inside {OP_RTYPE, OP_SPEC}) ? ins[15:11] : ins[20:16];
      case (ins[31:26])
        OP_RTYPE: begin
          case (ins[5:0])
            F_ADD:   val = a + b;
            F_SUB:   val = a - b;
            F_AND:   val = a & b;
            F_OR:    val = a | b;
            F_XOR:   val = a ^ b;
            F_SLT:   val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: val = '0;
          endcase
        end
        OP_SPEC: val = (ins[5:0] == F_MUL) ? a * b : '0;  // low word of the product
        OP_ADDI: val = ea;
        OP_SLTI: val = ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0;
        OP_ANDI: val = a & zext;
        OP_ORI:  val = a | zext;
        OP_XORI: val = a ^ zext;
        OP_LW:   val = dmem[ea[DMEM_AW+1:2]];
        OP_SW: begin
          dmem[ea[DMEM_AW+1:2]] = b;
          store_q.push_back(store_t'{addr: ea, data: b});
        end
        OP_BEQ: begin
          if (a == b) begin
            nnpc = npc + (sext << 2);
          end
        end
        OP_J:    nnpc = {npc[31:28], ins[25:0], 2'b00};
        default: val = '0;  // JAL and unused opcodes
      endcase
      if (wr) begin
        commit_q.push_back(commit_t'{reg_addr: dst, data: val});
        if (dst != 5'd0) begin
          regs[dst] = val;  // r0 write is traced and then dropped
        end
      end
      pc    = npc;
      npc   = nnpc;
      steps = steps + 1;
    end
    if (pc != END_PC) begin
      $display("the model never reached the final self jump");
      fail_count++;
    end
  endtask

  always @(posedge clk) begin
    if (rst_n && commit_valid) begin
      if (commit_q.size() == 0) begin
        $display("unexpected commit to r%0d after the expected trace ran out", commit.reg_addr);
        fail_count++;
      end else begin
        compare_commit($sformatf("commit_%0d", event_count), commit_q.pop_front(), commit);
      end
      event_count++;
    end
    if (rst_n && store_valid) begin
      if (store_q.size() == 0) begin
        $display("unexpected store to %h after the expected trace ran out", store.addr);
        fail_count++;
      end else begin
        compare_store($sformatf("store_%0d", event_count), store_q.pop_front(), store);
      end
      event_count++;
    end
  end

  initial begin
    int errors;
    int waited;
    rst_n <= 1'b0;
    lfsr = 32'ha3be93e3;
    build_program();
    run_model();
    $display("model: %0d commits and %0d stores expected", commit_q.size(), store_q.size());
    errors = fail_count;
    // ten reset edges, then two edges before the first instruction executes
    for (int i = 0; i < 12; i++) begin
      @(posedge clk);
      if (i == 9) begin
        rst_n <= 1'b1;
      end
      compare_word("reset_idle instr_addr", 32'd0, instr_addr);
      compare_word("reset_idle strobes", 32'd0, {30'd0, commit_valid, store_valid});
      if (i <= 9) begin
        compare_word("reset_idle instr_valid", 32'd0, {31'd0, instr_valid});
      end else if (i == 11) begin
        compare_word("reset_idle instr_valid", 32'd1, {31'd0, instr_valid});
      end
    end
    $display("[reset_idle] done, %0d errors", fail_count - errors);
    errors = fail_count;
    waited = 0;
    while ((commit_q.size() != 0 || store_q.size() != 0) && waited < TIMEOUT) begin
      @(negedge clk);
      compare_word("program_trace instr_valid", 32'd1, {31'd0, instr_valid});
      waited++;
    end
    if (commit_q.size() != 0 || store_q.size() != 0) begin
      $display("timeout: %0d commits and %0d stores never showed up",
               commit_q.size(), store_q.size());
      fail_count++;
    end
    $display("[program_trace] done, %0d events, %0d errors", event_count, fail_count - errors);
    errors = fail_count;
    waited = 0;
    while (waited < 16) begin  // core spins on the self jump so nothing more may commit
      @(negedge clk);
      compare_word("trailing_idle instr_valid", 32'd1, {31'd0, instr_valid});
      waited++;
    end
    $display("[trailing_idle] done, %0d errors", fail_count - errors);
    $display("checks: %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
hdl/mips_pkg.sv
hdl/fetch_unit.sv
hdl/control.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/data_mem.sv
hdl/mips_core.sv
dv/mips_core_tb.sv

//--- hdl/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  wire mips_pkg::ctrl_t ctrl,
  input  wire [31:0]           instr,
  input  wire [31:0]           rs_data,
  input  wire [31:0]           rt_data,
  output logic [31:0]          result,
  output logic                 branch_eq
);
  import mips_pkg::*;

  opcode_e     opcode;
  funct_e      funct;
  logic        zero_ext;
  logic [31:0] imm_ext;
  logic [31:0] op_b;

  assign opcode   = opcode_e'(instr[31:26]);
  assign funct    = funct_e'(instr[5:0]);
  assign zero_ext = opcode inside {OP_ANDI, OP_ORI, OP_XORI};  // logical immediates
  assign imm_ext  = zero_ext ? {16'h0000, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};
  assign op_b     = ctrl.alu_src_b ? imm_ext : rt_data;

  assign branch_eq = ctrl.rt_is_source && (rs_data == rt_data);

  always_comb begin
    result = '0;
    case (ctrl.alu_op)
      ALU_ADD: result = rs_data + op_b;
      ALU_FUNCT: begin
        if (ctrl.imm_command) begin
          case (opcode)
            OP_ADDI: result = rs_data + op_b;
            OP_SLTI: result = {31'd0, $signed(rs_data) < $signed(op_b)};
            OP_ANDI: result = rs_data & op_b;
            OP_ORI:  result = rs_data | op_b;
            OP_XORI: result = rs_data ^ op_b;
            default: result = '0;
          endcase
        end else begin
          case (funct)
            F_ADD:   result = rs_data + op_b;
            F_SUB:   result = rs_data - op_b;
            F_AND:   result = rs_data & op_b;
            F_OR:    result = rs_data | op_b;
            F_XOR:   result = rs_data ^ op_b;
            F_SLT:   result = {31'd0, $signed(rs_data) < $signed(op_b)};
            default: result = '0;
          endcase
        end
      end
      ALU_SPEC: result = (funct == F_MUL) ? rs_data * op_b : '0;  // low word only
      default:  result = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- hdl/control.sv
`timescale 1ns/1ps
`default_nettype none

module control (
  input  wire mips_pkg::opcode_e opcode,
  input  wire                    valid,
  input  wire                    branch_eq,  // rs == rt from the alu
  output mips_pkg::pc_src_e      pc_src,
  output mips_pkg::ctrl_t        ctrl
);
  import mips_pkg::*;

  logic memory_op;
  logic r_type_op;
  logic imm_op;
  logic branch_op;
  logic jump_op;
  logic spec_op;

  // instruction classes, all dead when the execute slot is empty
  assign memory_op = valid && (opcode == OP_LW || opcode == OP_SW);
  assign r_type_op = valid && (opcode == OP_RTYPE);
  assign imm_op    = valid && (opcode inside {OP_ADDI, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI});
  assign branch_op = valid && (opcode == OP_BEQ);
  assign jump_op   = valid && (opcode == OP_J);
  assign spec_op   = valid && (opcode == OP_SPEC);

  always_comb begin
    ctrl        = '0;
    ctrl.alu_op = ALU_ADD;
    if (memory_op) begin
      ctrl.alu_src_b   = 1'b1;     // base + offset
      ctrl.dst_reg_sel = 1'b0;     // rt
      ctrl.mem_to_reg  = 1'b1;
      if (opcode == OP_LW) begin
        ctrl.mem_read  = 1'b1;
        ctrl.reg_write = 1'b1;
      end else begin
        ctrl.mem_write    = 1'b1;
        ctrl.rt_is_source = 1'b1;  // store data
      end
    end else if (r_type_op) begin
      ctrl.rt_is_source = 1'b1;
      ctrl.dst_reg_sel  = 1'b1;    // rd
      ctrl.alu_op       = ALU_FUNCT;
      ctrl.reg_write    = 1'b1;
    end else if (imm_op) begin
      ctrl.imm_command = 1'b1;
      ctrl.alu_src_b   = 1'b1;
      ctrl.alu_op      = ALU_FUNCT;
      ctrl.reg_write   = 1'b1;
    end else if (branch_op) begin
      ctrl.rt_is_source = 1'b1;    // compared against rs
    end else if (spec_op) begin
      ctrl.rt_is_source = 1'b1;
      ctrl.dst_reg_sel  = 1'b1;
      ctrl.alu_op       = ALU_SPEC;
      ctrl.reg_write    = 1'b1;
    end
  end

  // kept apart from the bundle so branch_eq never feeds back into ctrl
  always_comb begin
    if (branch_op && branch_eq) begin
      pc_src = PC_BRANCH;
    end else if (jump_op) begin
      pc_src = PC_JUMP;
    end else begin
      pc_src = PC_SEQ;
    end
  end

endmodule

`default_nettype wire

//--- hdl/data_mem.sv
`timescale 1ns/1ps
`default_nettype none

module data_mem #(
  parameter int DMEM_AW = 8
) (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire mips_pkg::ctrl_t ctrl,
  input  wire                  valid,
  input  wire [31:0]           addr,
  input  wire [31:0]           wdata,
  output logic [31:0]          rdata,
  output logic                 store_valid,
  output mips_pkg::store_t     store
);

  localparam int DEPTH = 2 ** DMEM_AW;

  logic [31:0]        mem [DEPTH];
  logic [DMEM_AW-1:0] word_idx;

  assign word_idx = addr[DMEM_AW+1:2];  // wraps modulo depth

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (ctrl.mem_write && valid) begin
      mem[word_idx] <= wdata;
    end
  end

  assign rdata       = ctrl.mem_read ? mem[word_idx] : 32'd0;
  assign store_valid = ctrl.mem_write && valid;
  assign store       = '{addr: addr, data: wdata};

endmodule

`default_nettype wire

//--- hdl/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
  input  wire                    clk,
  input  wire                    rst_n,
  input  wire [31:0]             instr_data,
  input  wire mips_pkg::pc_src_e pc_src,
  output logic [31:0]            instr_addr,
  output logic                   instr_valid,
  output logic [31:0]            ex_instr,
  output logic [31:0]            ex_pc4,
  output logic                   ex_valid
);
  import mips_pkg::*;

  logic [31:0] pc;
  logic [31:0] pc_next;
  logic [31:0] branch_target;
  logic [31:0] jump_target;
  logic        live;

  // targets are relative to the delay slot address
  assign branch_target = ex_pc4 + {{14{ex_instr[15]}}, ex_instr[15:0], 2'b00};
  assign jump_target   = {ex_pc4[31:28], ex_instr[25:0], 2'b00};

  always_comb begin
    case (pc_src)
      PC_BRANCH: pc_next = branch_target;
      PC_JUMP:   pc_next = jump_target;
      default:   pc_next = pc + 32'd4;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc       <= '0;
      live     <= 1'b0;
      ex_instr <= '0;     // inert while ex_valid is low
      ex_pc4   <= '0;
      ex_valid <= 1'b0;
    end else if (live) begin
      pc       <= pc_next;
      ex_instr <= instr_data;
      ex_pc4   <= pc + 32'd4;
      ex_valid <= 1'b1;
    end else begin
      live <= 1'b1;       // first cycle out of reset
    end
  end

  assign instr_addr  = pc;
  assign instr_valid = live;

endmodule

`default_nettype wire

//--- hdl/mips_core.sv
`timescale 1ns/1ps
`default_nettype none

module mips_core #(
  parameter int DMEM_AW = 8
) (
  input  wire                clk,
  input  wire                rst_n,
  output logic [31:0]        instr_addr,
  output logic               instr_valid,
  input  wire  [31:0]        instr_data,
  output logic               commit_valid,
  output mips_pkg::commit_t  commit,
  output logic               store_valid,
  output mips_pkg::store_t   store
);
  import mips_pkg::*;

  logic [31:0] ex_instr;
  logic        ex_valid;
  pc_src_e     pc_src;
  ctrl_t       ctrl;
  logic        branch_eq;
  logic [31:0] rs_data;
  logic [31:0] rt_data;
  logic [31:0] alu_result;
  logic [31:0] mem_rdata;
  logic [4:0]  wr_addr;
  logic [31:0] wr_data;
  logic        reg_we;

  fetch_unit fetch_unit_inst (.clk, .rst_n, .instr_data, .pc_src, .instr_addr,
                              .instr_valid, .ex_instr, .ex_pc4(), .ex_valid);

  control control_inst (.opcode(opcode_e'(ex_instr[31:26])), .valid(ex_valid),
                        .branch_eq, .pc_src, .ctrl);

  reg_file reg_file_inst (.clk, .rst_n, .rs_addr(ex_instr[25:21]),
                          .rt_addr(ex_instr[20:16]), .rs_data, .rt_data,
                          .we(reg_we), .wr_addr, .wr_data);

  alu alu_inst (.ctrl, .instr(ex_instr), .rs_data, .rt_data, .result(alu_result),
                .branch_eq);

  data_mem #(.DMEM_AW(DMEM_AW)) data_mem_inst (.clk, .rst_n, .ctrl, .valid(ex_valid),
                                               .addr(alu_result), .wdata(rt_data),
                                               .rdata(mem_rdata), .store_valid, .store);

  assign wr_addr = ctrl.dst_reg_sel ? ex_instr[15:11] : ex_instr[20:16];  // rd or rt
  assign wr_data = ctrl.mem_to_reg ? mem_rdata : alu_result;
  assign reg_we  = ctrl.reg_write && ex_valid;

  // r0 writes are traced even though the register file drops them
  assign commit_valid = reg_we;
  assign commit       = '{reg_addr: wr_addr, data: wr_data};

endmodule

`default_nettype wire

//--- hdl/mips_pkg.sv
`default_nettype none

package mips_pkg;

  typedef enum logic [5:0] {
    OP_RTYPE = 6'b000000,
    OP_J     = 6'b000010,
    OP_JAL   = 6'b000011,  // decoded as a no-op
    OP_BEQ   = 6'b000100,
    OP_ADDI  = 6'b001000,
    OP_SLTI  = 6'b001010,
    OP_ANDI  = 6'b001100,
    OP_ORI   = 6'b001101,
    OP_XORI  = 6'b001110,
    OP_SPEC  = 6'b011100,  // special2 group
    OP_LW    = 6'b100011,
    OP_SW    = 6'b101011
  } opcode_e;

  typedef enum logic [5:0] {
    F_MUL = 6'b000010,     // only under OP_SPEC
    F_ADD = 6'b100000,
    F_SUB = 6'b100010,
    F_AND = 6'b100100,
    F_OR  = 6'b100101,
    F_XOR = 6'b100110,
    F_SLT = 6'b101010
  } funct_e;

  typedef enum logic [1:0] {
    ALU_ADD   = 2'b00,     // address calculation
    ALU_FUNCT = 2'b10,     // funct field, or opcode for immediates
    ALU_SPEC  = 2'b11
  } alu_op_e;

  typedef enum logic [1:0] {
    PC_SEQ    = 2'b00,
    PC_BRANCH = 2'b01,
    PC_JUMP   = 2'b10
  } pc_src_e;

  typedef struct packed {
    logic    rt_is_source;
    logic    imm_command;
    logic    alu_src_b;    // 1 selects the immediate
    logic    dst_reg_sel;  // 1 selects rd, 0 selects rt
    alu_op_e alu_op;
    logic    mem_read;
    logic    mem_write;
    logic    mem_to_reg;
    logic    reg_write;
  } ctrl_t;

  typedef struct packed {
    logic [4:0]  reg_addr;
    logic [31:0] data;
  } commit_t;

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] data;
  } store_t;

endpackage

`default_nettype wire

//--- hdl/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  wire         clk,
  input  wire         rst_n,
  input  wire  [4:0]  rs_addr,
  input  wire  [4:0]  rt_addr,
  output logic [31:0] rs_data,
  output logic [31:0] rt_data,
  input  wire         we,
  input  wire  [4:0]  wr_addr,
  input  wire  [31:0] wr_data
);

  logic [31:0] regs [32];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && wr_addr != 5'd0) begin  // r0 stays zero
      regs[wr_addr] <= wr_data;
    end
  end

  assign rs_data = (rs_addr == 5'd0) ? 32'd0 : regs[rs_addr];
  assign rt_data = (rt_addr == 5'd0) ? 32'd0 : regs[rt_addr];

endmodule

`default_nettype wire
